/* include/lsu_config.svh */
// LSU configuration macros
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// bus and datapath widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// one strobe bit per data byte
`define LSU_STRB_W (`LSU_DATA_W / 8)

// AXI id width on all channels
`define LSU_ID_W 4

// slaves answer SLVERR from this address up
`define LSU_FAULT_BASE 32'h8000_0000

`endif

/* logic/mem_pkg.sv */
// Memory operation types
`default_nettype none

package mem_pkg;

    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_lbu  = 4'd4,
        op_lhu  = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } mem_op_t;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_read  = 2'd1, // waiting on R after AR
        st_write = 2'd2  // waiting on B after AW and W
    } access_state_t;

    function automatic logic is_load(mem_op_t op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

endpackage

`default_nettype wire

/* logic/axi_pkg.sv */
// AXI4 field encodings
`default_nettype none

package axi_pkg;

    typedef enum logic [2:0] {
        size_byte = 3'b000,
        size_half = 3'b001,
        size_word = 3'b010
    } axi_size_t;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01
    } axi_burst_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_t;

endpackage

`default_nettype wire

/* logic/stage_if.sv */
// Access to writeback link
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

interface stage_if
    import mem_pkg::*;
();

    logic                   valid; // single-cycle strobe without ready
    logic [`LSU_ADDR_W-1:0] pc;
    logic [4:0]             rd;
    logic                   reg_we;
    mem_op_t                op;
    logic [`LSU_DATA_W-1:0] result; // alu result or address
    logic [`LSU_DATA_W-1:0] rdata;  // raw bus word
    logic                   fault;

    modport source (
        output valid, pc, rd, reg_we, op, result, rdata, fault
    );

    modport sink (
        input valid, pc, rd, reg_we, op, result, rdata, fault
    );

endinterface

`default_nettype wire

/* logic/load_align.sv */
// Load data alignment
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module load_align
    import mem_pkg::*;
(
    input  mem_op_t                op,
    input  logic [1:0]             offset,
    input  logic [`LSU_DATA_W-1:0] rdata,
    output logic [`LSU_DATA_W-1:0] data
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    assign lane_byte = rdata[{offset, 3'b000} +: 8];
    assign lane_half = rdata[{offset[1], 4'b0000} +: 16]; // offset bit 0 ignored

    always_comb begin
        case (op)
            op_lb: begin
                data = {{(`LSU_DATA_W-8){lane_byte[7]}}, lane_byte};
            end
            op_lbu: begin
                data = {{(`LSU_DATA_W-8){1'b0}}, lane_byte};
            end
            op_lh: begin
                data = {{(`LSU_DATA_W-16){lane_half[15]}}, lane_half};
            end
            op_lhu: begin
                data = {{(`LSU_DATA_W-16){1'b0}}, lane_half};
            end
            default: begin
                data = rdata; // whole word for lw
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/mem_access.sv */
// Memory access stage
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module mem_access
    import mem_pkg::*;
    import axi_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   ex_valid,
    input  mem_op_t                ex_op,
    input  logic [`LSU_ADDR_W-1:0] ex_pc,
    input  logic [4:0]             ex_rd,
    input  logic                   ex_reg_we,
    input  logic [`LSU_DATA_W-1:0] ex_result,
    input  logic [`LSU_DATA_W-1:0] ex_store_data,
    output logic                   ex_ready,
    output logic                   awvalid,
    input  logic                   awready,
    output logic [`LSU_ADDR_W-1:0] awaddr,
    output logic [`LSU_ID_W-1:0]   awid,
    output logic [7:0]             awlen,
    output axi_size_t              awsize,
    output axi_burst_t             awburst,
    output logic                   wvalid,
    input  logic                   wready,
    output logic [`LSU_DATA_W-1:0] wdata,
    output logic [`LSU_STRB_W-1:0] wstrb,
    output logic                   wlast,
    input  logic                   bvalid,
    output logic                   bready,
    input  logic [1:0]             bresp,
    input  logic [`LSU_ID_W-1:0]   bid,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [`LSU_ADDR_W-1:0] araddr,
    output logic [`LSU_ID_W-1:0]   arid,
    output logic [7:0]             arlen,
    output axi_size_t              arsize,
    output axi_burst_t             arburst,
    input  logic                   rvalid,
    output logic                   rready,
    input  logic [`LSU_DATA_W-1:0] rdata,
    input  logic [1:0]             rresp,
    input  logic [`LSU_ID_W-1:0]   rid,
    input  logic                   rlast,
    stage_if.source                stage
);

    localparam logic [`LSU_ID_W-1:0] axi_id = 'h1;

    access_state_t          state;
    mem_op_t                op_q;
    logic [`LSU_ADDR_W-1:0] pc_q;
    logic [4:0]             rd_q;
    logic                   reg_we_q;
    logic [`LSU_DATA_W-1:0] result_q;
    logic [`LSU_DATA_W-1:0] store_q;
    logic [`LSU_DATA_W-1:0] rdata_q;
    logic                   fault_q;
    logic                   valid_q;
    logic                   accept;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   b_hs;
    logic                   ar_hs;
    logic                   r_hs;
    logic [1:0]             offset;
    logic                   r_bad;
    logic                   b_bad;

    function automatic axi_size_t access_size(mem_op_t op);
        case (op)
            op_lb, op_lbu, op_sb: return size_byte;
            op_lh, op_lhu, op_sh: return size_half;
            default:              return size_word;
        endcase
    endfunction

    assign ex_ready = (state == st_idle);
    assign accept   = ex_valid & ex_ready;
    assign aw_hs    = awvalid & awready;
    assign w_hs     = wvalid & wready;
    assign b_hs     = bvalid & bready;
    assign ar_hs    = arvalid & arready;
    assign r_hs     = rvalid & rready;
    assign offset   = result_q[1:0];

    // single beat, so anything but our id with rlast is bad
    assign r_bad = (axi_resp_t'(rresp) != resp_okay) || (rid != axi_id) || !rlast;
    assign b_bad = (axi_resp_t'(bresp) != resp_okay) || (bid != axi_id);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept && is_load(ex_op))
                        state <= st_read;
                    else if (accept && is_store(ex_op))
                        state <= st_write;
                end
                st_read:  if (r_hs) state <= st_idle;
                st_write: if (b_hs) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            op_q     <= ex_op;
            pc_q     <= ex_pc;
            rd_q     <= ex_rd;
            reg_we_q <= ex_reg_we;
            result_q <= ex_result;
            store_q  <= ex_store_data;
        end
    end

    // each valid/ready drops on its own handshake
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else if (accept && is_store(ex_op)) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            bready  <= 1'b1;
        end else if (accept && is_load(ex_op)) begin
            arvalid <= 1'b1;
            rready  <= 1'b1;
        end else begin
            if (aw_hs) awvalid <= 1'b0;
            if (w_hs)  wvalid  <= 1'b0;
            if (b_hs)  bready  <= 1'b0;
            if (ar_hs) arvalid <= 1'b0;
            if (r_hs)  rready  <= 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            valid_q <= (accept && !is_load(ex_op) && !is_store(ex_op)) ||
                       (state == st_read && r_hs) ||
                       (state == st_write && b_hs);
            if (accept)
                fault_q <= 1'b0;
            else if (r_hs)
                fault_q <= r_bad;
            else if (b_hs)
                fault_q <= b_bad;
        end
    end

    always_ff @(posedge clock) begin
        if (r_hs)
            rdata_q <= rdata;
    end

    // place store bytes on their lanes
    always_comb begin
        case (op_q)
            op_sb: begin
                wdata = store_q << {offset, 3'b000};
                wstrb = 4'b0001 << offset;
            end
            op_sh: begin
                wdata = store_q << {offset[1], 4'b0000};
                wstrb = 4'b0011 << {offset[1], 1'b0};
            end
            op_sw: begin
                wdata = store_q;
                wstrb = 4'b1111;
            end
            default: begin
                wdata = store_q;
                wstrb = 4'b0000;
            end
        endcase
    end

    assign awaddr  = result_q[`LSU_ADDR_W-1:0];
    assign awid    = axi_id;
    assign awlen   = 8'd0; // single beat
    assign awsize  = access_size(op_q);
    assign awburst = burst_incr;
    assign wlast   = wvalid;
    assign araddr  = result_q[`LSU_ADDR_W-1:0];
    assign arid    = axi_id;
    assign arlen   = 8'd0;
    assign arsize  = access_size(op_q);
    assign arburst = burst_incr;

    assign stage.valid  = valid_q;
    assign stage.pc     = pc_q;
    assign stage.rd     = rd_q;
    assign stage.reg_we = reg_we_q;
    assign stage.op     = op_q;
    assign stage.result = result_q;
    assign stage.rdata  = rdata_q;
    assign stage.fault  = fault_q;

endmodule

`default_nettype wire

/* logic/writeback_stage.sv */
// Writeback stage
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module writeback_stage
    import mem_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    stage_if.sink                  stage,
    output logic                   wb_valid,
    output logic [`LSU_ADDR_W-1:0] wb_pc,
    output logic [4:0]             wb_rd,
    output logic                   wb_we,
    output logic [`LSU_DATA_W-1:0] wb_data,
    output logic                   wb_fault
);

    logic [`LSU_DATA_W-1:0] load_data;

    load_align u_load_align (
        .op     (stage.op),
        .offset (stage.result[1:0]),
        .rdata  (stage.rdata),
        .data   (load_data)
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= stage.valid; // always accepted downstream
        end
    end

    always_ff @(posedge clock) begin
        if (stage.valid) begin
            wb_pc    <= stage.pc;
            wb_rd    <= stage.rd;
            wb_we    <= stage.reg_we & ~stage.fault; // no write on bus error
            wb_fault <= stage.fault;
            wb_data  <= is_load(stage.op) ? load_data : stage.result;
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
// Load store unit top
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_top
    import mem_pkg::*;
    import axi_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   ex_valid,
    input  mem_op_t                ex_op,
    input  logic [`LSU_ADDR_W-1:0] ex_pc,
    input  logic [4:0]             ex_rd,
    input  logic                   ex_reg_we,
    input  logic [`LSU_DATA_W-1:0] ex_result,
    input  logic [`LSU_DATA_W-1:0] ex_store_data,
    output logic                   ex_ready,
    output logic                   awvalid,
    input  logic                   awready,
    output logic [`LSU_ADDR_W-1:0] awaddr,
    output logic [`LSU_ID_W-1:0]   awid,
    output logic [7:0]             awlen,
    output axi_size_t              awsize,
    output axi_burst_t             awburst,
    output logic                   wvalid,
    input  logic                   wready,
    output logic [`LSU_DATA_W-1:0] wdata,
    output logic [`LSU_STRB_W-1:0] wstrb,
    output logic                   wlast,
    input  logic                   bvalid,
    output logic                   bready,
    input  logic [1:0]             bresp,
    input  logic [`LSU_ID_W-1:0]   bid,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [`LSU_ADDR_W-1:0] araddr,
    output logic [`LSU_ID_W-1:0]   arid,
    output logic [7:0]             arlen,
    output axi_size_t              arsize,
    output axi_burst_t             arburst,
    input  logic                   rvalid,
    output logic                   rready,
    input  logic [`LSU_DATA_W-1:0] rdata,
    input  logic [1:0]             rresp,
    input  logic [`LSU_ID_W-1:0]   rid,
    input  logic                   rlast,
    output logic                   wb_valid,
    output logic [`LSU_ADDR_W-1:0] wb_pc,
    output logic [4:0]             wb_rd,
    output logic                   wb_we,
    output logic [`LSU_DATA_W-1:0] wb_data,
    output logic                   wb_fault
);

    stage_if u_stage_if ();

    // execute and AXI ports match by name
    mem_access u_mem_access (
        .stage (u_stage_if.source),
        .*
    );

    writeback_stage u_writeback_stage (
        .clock    (clock),
        .reset    (reset),
        .stage    (u_stage_if.sink),
        .wb_valid (wb_valid),
        .wb_pc    (wb_pc),
        .wb_rd    (wb_rd),
        .wb_we    (wb_we),
        .wb_data  (wb_data),
        .wb_fault (wb_fault)
    );

endmodule

`default_nettype wire

/* testbench/axi_mem_model.sv */
// AXI memory model
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module axi_mem_model
    import axi_pkg::*;
#(
    parameter int seed_init = 1
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`LSU_ADDR_W-1:0] awaddr,
    input  logic [`LSU_ID_W-1:0]   awid,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [`LSU_DATA_W-1:0] wdata,
    input  logic [`LSU_STRB_W-1:0] wstrb,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    output logic [`LSU_ID_W-1:0]   bid,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`LSU_ADDR_W-1:0] araddr,
    input  logic [`LSU_ID_W-1:0]   arid,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`LSU_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,
    output logic [`LSU_ID_W-1:0]   rid,
    output logic                   rlast
);

    logic [`LSU_DATA_W-1:0] mem [0:255]; // wraps every 1 KiB
    integer                 seed;
    logic                   w_fault;
    logic                   r_fault;

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5aa5_c33c;
    endfunction

    task automatic wait_random();
        repeat ({$random(seed)} % 4) begin
            @(posedge clock);
            #1;
        end
    endtask

    initial begin
        seed = seed_init;
        for (int i = 0; i < 256; i++)
            mem[i] = fill_word(i * 4);
    end

    initial begin : write_side
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = resp_okay;
        bid     = '0;
        forever begin
            @(posedge clock);
            #1;
            if (awvalid && wvalid && !reset) begin
                wait_random();
                awready = 1'b1; // AW and W accepted together
                wready  = 1'b1;
                @(posedge clock);
                #1;
                awready = 1'b0;
                wready  = 1'b0;
                w_fault = (awaddr >= `LSU_FAULT_BASE);
                for (int i = 0; i < 4; i++)
                    if (wstrb[i] && !w_fault)
                        mem[awaddr[9:2]][8*i +: 8] = wdata[8*i +: 8];
                wait_random();
                bvalid = 1'b1;
                bresp  = w_fault ? resp_slverr : resp_okay;
                bid    = awid;
                @(posedge clock); // bready held high while waiting
                #1;
                bvalid = 1'b0;
            end
        end
    end

    initial begin : read_side
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = resp_okay;
        rid     = '0;
        rlast   = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            if (arvalid && !reset) begin
                wait_random();
                arready = 1'b1;
                @(posedge clock);
                #1;
                arready = 1'b0;
                r_fault = (araddr >= `LSU_FAULT_BASE);
                wait_random();
                rvalid = 1'b1;
                rdata  = r_fault ? '0 : mem[araddr[9:2]];
                rresp  = r_fault ? resp_slverr : resp_okay;
                rid    = arid;
                rlast  = 1'b1;
                @(posedge clock);
                #1;
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_lsu.sv */
// LSU testbench
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module tb_lsu
    import mem_pkg::*;
    import axi_pkg::*;
();

    localparam int total_instr = 42; // sum over the five test groups below
    localparam int limit_cycles = total_instr * 200 + 10;

    logic        clock;
    logic        reset;
    logic        ex_valid, ex_reg_we, ex_ready;
    mem_op_t     ex_op;
    logic [31:0] ex_pc, ex_result, ex_store_data;
    logic [4:0]  ex_rd;
    logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic        arvalid, arready, rvalid, rready, rlast;
    logic [31:0] awaddr, araddr, wdata, rdata;
    logic [3:0]  awid, bid, arid, rid, wstrb;
    logic [7:0]  awlen, arlen;
    axi_size_t   awsize, arsize;
    axi_burst_t  awburst, arburst;
    logic [1:0]  bresp, rresp;
    logic        wb_valid, wb_we, wb_fault;
    logic [31:0] wb_pc, wb_data;
    logic [4:0]  wb_rd;

    logic [31:0] shadow [0:255];
    logic [31:0] exp_data [0:63];
    logic [31:0] exp_pc [0:63];
    logic [4:0]  exp_rd [0:63];
    logic        exp_we [0:63];
    logic        exp_fault [0:63];
    logic        exp_chk [0:63]; // data unknown for faulting loads
    int          issued, wb_idx, mismatches, failures;
    integer      seed;
    logic [31:0] cur_addr, cur_wdata, cur_mask;
    logic [3:0]  cur_wstrb;
    axi_size_t   cur_size;
    logic        ar_pending, aw_pending;
    logic [31:0] want_data, want_pc;
    logic [4:0]  want_rd;
    logic        want_we, want_fault, want_chk;

    lsu_top u_lsu_top (.*);

    axi_mem_model #(.seed_init(32'h3521_f8a8)) u_axi_mem_model (.*);

    initial clock = 1'b0;
    always #50 clock = ~clock;

    assign want_data  = exp_data[wb_idx];
    assign want_pc    = exp_pc[wb_idx];
    assign want_rd    = exp_rd[wb_idx];
    assign want_we    = exp_we[wb_idx];
    assign want_fault = exp_fault[wb_idx];
    assign want_chk   = exp_chk[wb_idx];
    assign cur_mask   = {{8{cur_wstrb[3]}}, {8{cur_wstrb[2]}},
                         {8{cur_wstrb[1]}}, {8{cur_wstrb[0]}}};

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_idx     <= 0;
            ar_pending <= 1'b0;
            aw_pending <= 1'b0;
        end else begin
            if (wb_valid)
                wb_idx <= wb_idx + 1;
            if (arvalid && arready)
                ar_pending <= 1'b1;
            else if (rvalid && rready)
                ar_pending <= 1'b0;
            if (awvalid && awready)
                aw_pending <= 1'b1;
            else if (bvalid && bready)
                aw_pending <= 1'b0;
        end
    end

    task automatic log_mismatch(string name, logic [31:0] got, logic [31:0] want);
        mismatches++;
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
    endtask

    task automatic flag_failure(string what);
        failures++;
        $display("error at %0t: %s", $time, what);
    endtask

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5aa5_c33c;
    endfunction

    // bytes touched by each access
    function automatic int access_bytes(mem_op_t op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            default:              return 4;
        endcase
    endfunction

    // AXI size is log2 of the byte count
    function automatic axi_size_t size_for(mem_op_t op);
        int n;
        n = access_bytes(op);
        if (n == 1)
            return size_byte;
        else if (n == 2)
            return size_half;
        else
            return size_word;
    endfunction

    // live lanes start at the naturally aligned offset
    function automatic logic [3:0] strobe_for(mem_op_t op, logic [1:0] off);
        int         n;
        int         first;
        logic [3:0] strb;
        n     = access_bytes(op);
        first = off & ~(n - 1);
        strb  = 4'b0000;
        if (op inside {op_sb, op_sh, op_sw})
            for (int i = 0; i < 4; i++)
                strb[i] = (i >= first) && (i < first + n);
        return strb;
    endfunction

    // store value repeated on every lane
    function automatic logic [31:0] lanes_for(mem_op_t op, logic [31:0] value);
        case (op)
            op_sb:   return {4{value[7:0]}};
            op_sh:   return {2{value[15:0]}};
            default: return value;
        endcase
    endfunction

    function automatic logic [31:0] load_value(mem_op_t op, logic [31:0] word, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            op_lb:   return {{24{b[7]}}, b};
            op_lbu:  return {24'd0, b};
            op_lh:   return {{16{h[15]}}, h};
            op_lhu:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic issue_instr(mem_op_t op, logic [31:0] result, logic [31:0] value);
        logic       load;
        logic       fault;
        logic       we;
        logic [7:0] idx;
        load  = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
        fault = (op != op_none) && (result >= `LSU_FAULT_BASE);
        we    = load || (op == op_none && ($random(seed) & 1));
        idx   = result[9:2];
        while (!ex_ready) begin
            @(posedge clock);
            #1;
        end
        cur_addr          = result;
        cur_size          = size_for(op);
        cur_wstrb         = strobe_for(op, result[1:0]);
        cur_wdata         = lanes_for(op, value);
        exp_pc[issued]    = 32'h100 + 4 * issued;
        exp_rd[issued]    = issued[4:0] ^ 5'h15;
        exp_we[issued]    = we && !fault;
        exp_fault[issued] = fault;
        exp_chk[issued]   = !(load && fault);
        exp_data[issued]  = load ? load_value(op, shadow[idx], result[1:0]) : result;
        if (!fault)
            for (int i = 0; i < 4; i++)
                if (cur_wstrb[i])
                    shadow[idx][8*i +: 8] = cur_wdata[8*i +: 8];
        ex_valid      = 1'b1;
        ex_op         = op;
        ex_pc         = exp_pc[issued];
        ex_rd         = exp_rd[issued];
        ex_reg_we     = we;
        ex_result     = result;
        ex_store_data = value;
        @(posedge clock);
        #1;
        ex_valid = 1'b0;
        issued++;
    endtask

    a_reset_idle: assert property (@(posedge clock) $fell(reset) |->
        (ex_ready && !arvalid && !awvalid && !wvalid && !bready && !rready && !wb_valid))
        else flag_failure("outputs not idle after reset");
    a_alu_latency: assert property (@(posedge clock) disable iff (reset)
        (ex_valid && ex_ready && ex_op == op_none) |-> ##2 wb_valid)
        else flag_failure("no writeback two cycles after a non-memory instruction");
    a_wb_data: assert property (@(posedge clock) disable iff (reset)
        wb_valid |-> (!want_chk || wb_data == want_data))
        else log_mismatch("wb_data", $sampled(wb_data), $sampled(want_data));
    a_wb_we: assert property (@(posedge clock) disable iff (reset) wb_valid |-> wb_we == want_we)
        else log_mismatch("wb_we", $sampled(wb_we), $sampled(want_we));
    a_wb_fault: assert property (@(posedge clock) disable iff (reset)
        wb_valid |-> wb_fault == want_fault)
        else log_mismatch("wb_fault", $sampled(wb_fault), $sampled(want_fault));
    a_wb_pc: assert property (@(posedge clock) disable iff (reset) wb_valid |-> wb_pc == want_pc)
        else log_mismatch("wb_pc", $sampled(wb_pc), $sampled(want_pc));
    a_wb_rd: assert property (@(posedge clock) disable iff (reset) wb_valid |-> wb_rd == want_rd)
        else log_mismatch("wb_rd", $sampled(wb_rd), $sampled(want_rd));
    a_awaddr: assert property (@(posedge clock) disable iff (reset)
        awvalid |-> awaddr == cur_addr)
        else log_mismatch("awaddr", $sampled(awaddr), $sampled(cur_addr));
    a_awsize: assert property (@(posedge clock) disable iff (reset)
        awvalid |-> awsize == cur_size)
        else log_mismatch("awsize", $sampled(awsize), $sampled(cur_size));
    a_awlen: assert property (@(posedge clock) disable iff (reset)
        awvalid |-> awlen == 8'd0)
        else log_mismatch("awlen", $sampled(awlen), 32'd0);
    a_awburst: assert property (@(posedge clock) disable iff (reset)
        awvalid |-> awburst == burst_incr)
        else log_mismatch("awburst", $sampled(awburst), burst_incr);
    a_araddr: assert property (@(posedge clock) disable iff (reset)
        arvalid |-> araddr == cur_addr)
        else log_mismatch("araddr", $sampled(araddr), $sampled(cur_addr));
    a_arsize: assert property (@(posedge clock) disable iff (reset)
        arvalid |-> arsize == cur_size)
        else log_mismatch("arsize", $sampled(arsize), $sampled(cur_size));
    a_arlen: assert property (@(posedge clock) disable iff (reset)
        arvalid |-> arlen == 8'd0)
        else log_mismatch("arlen", $sampled(arlen), 32'd0);
    a_arburst: assert property (@(posedge clock) disable iff (reset)
        arvalid |-> arburst == burst_incr)
        else log_mismatch("arburst", $sampled(arburst), burst_incr);
    a_wstrb: assert property (@(posedge clock) disable iff (reset) wvalid |-> wstrb == cur_wstrb)
        else log_mismatch("wstrb", $sampled(wstrb), $sampled(cur_wstrb));
    a_wdata: assert property (@(posedge clock) disable iff (reset)
        wvalid |-> (wdata & cur_mask) == (cur_wdata & cur_mask))
        else log_mismatch("wdata", $sampled(wdata & cur_mask), $sampled(cur_wdata & cur_mask));
    a_wlast: assert property (@(posedge clock) disable iff (reset) wvalid |-> wlast)
        else flag_failure("wlast low on the only write beat");
    a_busy: assert property (@(posedge clock) disable iff (reset)
        (arvalid || rready || awvalid || wvalid || bready) |-> !ex_ready)
        else flag_failure("ex_ready high while an access is outstanding");
    a_one_ar: assert property (@(posedge clock) disable iff (reset) ar_pending |-> !arvalid)
        else flag_failure("second AR request while the read is outstanding");
    a_one_aw: assert property (@(posedge clock) disable iff (reset) aw_pending |-> !awvalid)
        else flag_failure("second AW request while the write is outstanding");
    a_ready_after_r: assert property (@(posedge clock) disable iff (reset)
        (rvalid && rready) |=> ex_ready)
        else flag_failure("ex_ready still low after the R handshake");
    a_ready_after_b: assert property (@(posedge clock) disable iff (reset)
        (bvalid && bready) |=> ex_ready)
        else flag_failure("ex_ready still low after the B handshake");

    initial begin : stimulus
        logic [31:0] addr;
        seed          = 32'h3521_f8a8;
        issued        = 0;
        mismatches    = 0;
        failures      = 0;
        ex_valid      = 1'b0;
        ex_op         = op_none;
        ex_pc         = '0;
        ex_rd         = '0;
        ex_reg_we     = 1'b0;
        ex_result     = '0;
        ex_store_data = '0;
        for (int i = 0; i < 256; i++)
            shadow[i] = fill_word(i * 4);
        reset = 1'b1;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        idle_cycles(1);
        for (int i = 0; i < 4; i++)
            issue_instr(op_none, $random(seed), 32'd0); // back to back
        for (int i = 0; i < 2; i++) begin
            idle_cycles(2);
            issue_instr(op_none, $random(seed), 32'd0);
        end
        for (int i = 0; i < 4; i++) begin
            addr = {$random(seed)} & 32'h3fc;
            issue_instr(op_sw, addr, $random(seed));
            issue_instr(op_lw, addr, 32'd0);
        end
        addr = {$random(seed)} & 32'h3fc;
        for (int off = 0; off < 4; off++) begin
            issue_instr(op_sb, addr + off, $random(seed));
            issue_instr(op_lw, addr, 32'd0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue_instr(op_sh, addr + off, $random(seed));
            issue_instr(op_lw, addr, 32'd0);
        end
        addr = {$random(seed)} & 32'h3fc;
        issue_instr(op_sw, addr, $random(seed));
        for (int off = 0; off < 4; off++) begin
            idle_cycles({$random(seed)} % 3);
            issue_instr(op_lb, addr + off, 32'd0);
            issue_instr(op_lbu, addr + off, 32'd0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue_instr(op_lh, addr + off, 32'd0);
            issue_instr(op_lhu, addr + off, 32'd0);
        end
        addr = `LSU_FAULT_BASE + ({$random(seed)} & 32'hfc); // bus error region
        issue_instr(op_sw, addr, $random(seed));
        issue_instr(op_lw, addr, 32'd0);
        issue_instr(op_lb, addr + 1, 32'd0);
        wait (wb_idx == issued);
        idle_cycles(5);
        assert (wb_idx == issued)
            else flag_failure("more writebacks than issued instructions");
        $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (limit_cycles) @(posedge clock);
        $display("error: run did not finish within %0d cycles", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
logic/mem_pkg.sv
logic/axi_pkg.sv
logic/stage_if.sv
logic/load_align.sv
logic/mem_access.sv
logic/writeback_stage.sv
logic/lsu_top.sv
testbench/axi_mem_model.sv
testbench/tb_lsu.sv
